/* Makefile */
TOP := int_core_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f compile.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* compile.f */
logic/rv_pkg.sv
logic/instr_buffer.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/operand_stage.sv
logic/execute_stage.sv
logic/int_core.sv
tests/tb_clock.sv
tests/int_core_chk.sv
tests/int_core_tb.sv

/* logic/decode_stage.sv */
`default_nettype none

module decode_stage (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire rv_pkg::instr_t  head,
  input  wire logic            not_empty,
  input  wire logic            hold,
  output logic                 pop,
  output rv_pkg::decoded_t     decoded
);
  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  decoded_t   rec;

  assign opcode = opcode_e'(head[6:0]);
  assign funct3 = head[14:12];
  assign funct7 = head[31:25];

  always_comb begin
    rec.rd      = head[11:7];
    rec.rs1     = head[19:15];
    rec.rs2     = head[24:20];
    rec.op      = OP_ILLEGAL;
    rec.imm     = '0;
    rec.use_imm = 1'b0;
    case (opcode)
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  rec.op = OP_ADD;
            3'b001:  rec.op = OP_SLL;
            3'b100:  rec.op = OP_XOR;
            3'b110:  rec.op = OP_OR;
            3'b111:  rec.op = OP_AND;
            default: rec.op = OP_ILLEGAL;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          rec.op = OP_SUB;
        end
      end
      OPC_OP_IMM: begin
        // Only ADDI among the immediate forms
        if (funct3 == 3'b000) begin
          rec.op      = OP_ADD;
          rec.use_imm = 1'b1;
          rec.imm     = {{(XLEN-12){head[31]}}, head[31:20]};
        end
      end
      OPC_LUI: begin
        rec.op      = OP_LUI;
        rec.use_imm = 1'b1;
        rec.imm     = {{(XLEN-32){head[31]}}, head[31:12], 12'b0};
      end
      default: rec.op = OP_ILLEGAL;
    endcase
    // Illegal words are consumed here and never move on
    rec.valid = not_empty && (rec.op != OP_ILLEGAL);
  end

  // Hold only rises with a valid record, so no hold means free or advancing
  assign pop = not_empty && !hold;

  always_ff @(posedge clk) begin
    if (reset) begin
      decoded.valid <= 1'b0;
    end else if (!hold) begin
      decoded <= rec;
    end
  end

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`default_nettype none

module execute_stage (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire rv_pkg::issue_t  issue,
  output rv_pkg::retire_t      retire
);
  import rv_pkg::*;

  word_t result;

  always_comb begin
    case (issue.op)
      OP_ADD:  result = issue.a + issue.b;
      OP_SUB:  result = issue.a - issue.b;
      OP_AND:  result = issue.a & issue.b;
      OP_OR:   result = issue.a | issue.b;
      OP_XOR:  result = issue.a ^ issue.b;
      // Shift amount from the low six bits
      OP_SLL:  result = issue.a << issue.b[SHAMT_W-1:0];
      OP_LUI:  result = issue.b;
      default: result = '0;
    endcase
  end

  // Also the register write port, so x0 writes still show up here
  always_ff @(posedge clk) begin
    if (reset) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= issue.valid;
      if (issue.valid) begin
        retire.rd    <= issue.rd;
        retire.value <= result;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/instr_buffer.sv */
`default_nettype none

module instr_buffer #(
  parameter int BUF_DEPTH = 4
) (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            instr_valid,
  input  wire rv_pkg::instr_t  instr,
  input  wire logic            pop,
  output rv_pkg::instr_t       head,
  output logic                 not_empty,
  output logic                 credit_return
);
  import rv_pkg::*;

  localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  instr_t           mem [BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop_fire;

  // Wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign not_empty = (count != '0);
  assign pop_fire  = pop && not_empty;
  assign head      = mem[rd_ptr];

  // Credits guarantee room, so writes are never refused
  always_ff @(posedge clk) begin
    if (instr_valid) begin
      mem[wr_ptr] <= instr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      if (instr_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_fire) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({instr_valid, pop_fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back per freed entry
      credit_return <= pop_fire;
    end
  end

endmodule

`default_nettype wire

/* logic/int_core.sv */
`default_nettype none

module int_core #(
  parameter int BUF_DEPTH = 4
) (
  input  wire logic            clk,
  input  wire logic            reset,
  input  wire logic            instr_valid,
  input  wire rv_pkg::instr_t  instr,
  output logic                 credit_return,
  output rv_pkg::retire_t      retire
);
  import rv_pkg::*;

  instr_t   head;
  logic     not_empty;
  logic     pop;
  logic     hold;
  decoded_t decoded;
  issue_t   issue;

  // Credited input queue
  instr_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) i_instr_buffer (
    .clk           (clk),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .pop           (pop),
    .head          (head),
    .not_empty     (not_empty),
    .credit_return (credit_return)
  );

  decode_stage i_decode_stage (
    .clk       (clk),
    .reset     (reset),
    .head      (head),
    .not_empty (not_empty),
    .hold      (hold),
    .pop       (pop),
    .decoded   (decoded)
  );

  // Retire feeds back for register write and busy clear
  operand_stage i_operand_stage (
    .clk     (clk),
    .reset   (reset),
    .decoded (decoded),
    .wb      (retire),
    .hold    (hold),
    .issue   (issue)
  );

  execute_stage i_execute_stage (
    .clk    (clk),
    .reset  (reset),
    .issue  (issue),
    .retire (retire)
  );

endmodule

`default_nettype wire

/* logic/operand_stage.sv */
`default_nettype none

module operand_stage (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire rv_pkg::decoded_t  decoded,
  input  wire rv_pkg::retire_t   wb,
  output logic                   hold,
  output rv_pkg::issue_t         issue
);
  import rv_pkg::*;

  logic [31:0] busy;
  word_t       rdata1;
  word_t       rdata2;
  logic        uses_rs1;
  logic        uses_rs2;
  logic        hazard;
  logic        fire;

  reg_file i_reg_file (
    .clk    (clk),
    .reset  (reset),
    .rs1    (decoded.rs1),
    .rs2    (decoded.rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wr     (wb)
  );

  // LUI reads no register, immediate forms skip rs2
  assign uses_rs1 = (decoded.op != OP_LUI);
  assign uses_rs2 = !decoded.use_imm;
  assign hazard   = (uses_rs1 && busy[decoded.rs1]) || (uses_rs2 && busy[decoded.rs2]);
  assign hold     = decoded.valid && hazard;
  assign fire     = decoded.valid && !hazard;

  // Scoreboard; a new issue to the same rd wins over a retire clear
  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= '0;
    end else begin
      // A younger write to the same rd sitting in issue keeps the bit set
      if (wb.valid && !(issue.valid && issue.rd == wb.rd)) begin
        busy[wb.rd] <= 1'b0;
      end
      if (fire && decoded.rd != '0) begin
        busy[decoded.rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= fire;
      if (fire) begin
        issue.op <= decoded.op;
        issue.rd <= decoded.rd;
        issue.a  <= rdata1;
        issue.b  <= decoded.use_imm ? decoded.imm : rdata2;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
`default_nettype none

module reg_file (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire rv_pkg::reg_addr_t rs1,
  input  wire rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t          rdata1,
  output rv_pkg::word_t          rdata2,
  input  wire rv_pkg::retire_t   wr
);
  import rv_pkg::*;

  word_t regs [32];

  // Entry zero is cleared by reset and never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.valid && wr.rd != '0) begin
      regs[wr.rd] <= wr.value;
    end
  end

  assign rdata1 = regs[rs1];
  assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // RV64 integer datapath
  parameter int XLEN = 64;
  parameter int REG_ADDR_W = 5;
  parameter int SHAMT_W = $clog2(XLEN);

  typedef logic [31:0] instr_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [XLEN-1:0] word_t;

  // Major opcodes the decoder recognises
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SLL,
    OP_LUI,
    OP_ILLEGAL
  } alu_op_e;

  // Decode stage output record
  typedef struct packed {
    logic      valid;
    alu_op_e   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
    logic      use_imm;
  } decoded_t;

  // Operand b already carries the immediate when one is used
  typedef struct packed {
    logic      valid;
    alu_op_e   op;
    reg_addr_t rd;
    word_t     a;
    word_t     b;
  } issue_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     value;
  } retire_t;

endpackage

`default_nettype wire

/* tests/int_core_chk.sv */
`default_nettype none

module int_core_chk #(
  parameter int BUF_DEPTH = 4
) (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             instr_valid,
  input  wire logic             credit_return,
  input  wire rv_pkg::retire_t  retire
);
  timeunit 1ns;
  timeprecision 100ps;

  int outstanding;

  // Entries sent and not yet credited back
  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(instr_valid) - int'(credit_return);
    end
  end

  quiet_after_reset: assert property (
    @(posedge clk) reset |=> !credit_return && !retire.valid
  ) else $error("Credit or retire active during or right after reset");

  credit_has_entry: assert property (
    @(posedge clk) disable iff (reset) credit_return |-> outstanding > 0
  ) else $error("Credit returned with no entry outstanding");

  outstanding_bound: assert property (
    @(posedge clk) disable iff (reset) outstanding <= BUF_DEPTH
  ) else $error("More entries outstanding than the buffer holds");

  retire_known: assert property (
    @(posedge clk) disable iff (reset) retire.valid |-> !$isunknown({retire.rd, retire.value})
  ) else $error("Unknown bits on a valid retire");

endmodule

bind int_core int_core_chk #(
  .BUF_DEPTH (BUF_DEPTH)
) i_int_core_chk (
  .clk           (clk),
  .reset         (reset),
  .instr_valid   (instr_valid),
  .credit_return (credit_return),
  .retire        (retire)
);

`default_nettype wire

/* tests/int_core_tb.sv */
`default_nettype none

module int_core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import rv_pkg::*;

  localparam int BUF_DEPTH = 4;
  localparam int NUM_INSTR = 200;
  localparam int MAX_CYCLES = NUM_INSTR * 8 + 100;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  instr_t      instr;
  logic        credit_return;
  retire_t     retire;
  logic [31:0] rnd;
  int          credits;
  int          sent;
  int          credits_back;
  int          cycles = 0;
  word_t       model [32];
  retire_t     expected_q [$];

  tb_clock i_tb_clock (
    .clk   (clk),
    .reset (reset)
  );

  int_core #(
    .BUF_DEPTH (BUF_DEPTH)
  ) i_int_core (
    .clk           (clk),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .instr         (instr),
    .credit_return (credit_return),
    .retire        (retire)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_run();
    $display("Errors found");
    $fatal(1);
  endtask

  // Random word on the bus, expected retire from the model registers
  task automatic send_instruction();
    logic [31:0] r;
    logic [11:0] imm12;
    logic [19:0] imm20;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    word_t       a;
    word_t       b;
    word_t       value;
    logic        legal;
    retire_t     exp;
    rnd = xorshift(rnd);
    r = rnd;
    rd = {2'b00, r[6:4]};
    rs1 = {2'b00, r[9:7]};
    rs2 = {2'b00, r[12:10]};
    imm12 = r[27:16];
    imm20 = r[31:12];
    a = model[rs1];
    b = model[rs2];
    value = '0;
    legal = 1'b1;
    if (r[3:0] < 4'd7) begin
      case (r[15:13])
        3'd1, 3'd7: begin
          instr = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
          value = a - b;
        end
        3'd2: begin
          instr = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
          value = a & b;
        end
        3'd3: begin
          instr = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
          value = a | b;
        end
        3'd4: begin
          instr = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
          value = a ^ b;
        end
        3'd5: begin
          instr = {7'b0000000, rs2, rs1, 3'b001, rd, 7'b0110011};
          value = a << b[5:0];
        end
        default: begin
          instr = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
          value = a + b;
        end
      endcase
    end else if (r[3:0] < 4'd11 || r[3:0] == 4'd13) begin
      // ADDI, with rd forced to x0 on one code
      if (r[3:0] == 4'd13) begin
        rd = '0;
      end
      instr = {imm12, rs1, 3'b000, rd, 7'b0010011};
      value = a + {{52{imm12[11]}}, imm12};
    end else if (r[3:0] < 4'd13) begin
      instr = {imm20, rd, 7'b0110111};
      value = {{32{imm20[19]}}, imm20, 12'b0};
    end else begin
      // Load, SLT, SRA and SLLI are all outside the supported set
      legal = 1'b0;
      case (r[14:13])
        2'd0:    instr = {imm12, rs1, 3'b011, rd, 7'b0000011};
        2'd1:    instr = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
        2'd2:    instr = {7'b0100000, rs2, rs1, 3'b101, rd, 7'b0110011};
        default: instr = {7'b0000000, 5'd3, rs1, 3'b001, rd, 7'b0010011};
      endcase
    end
    instr_valid = 1'b1;
    credits--;
    sent++;
    if (legal) begin
      exp.valid = 1'b1;
      exp.rd = rd;
      exp.value = value;
      expected_q.push_back(exp);
      if (rd != '0) begin
        model[rd] = value;
      end
    end
  endtask

  task automatic count_credit();
    assert (credits_back < sent) begin
      credits_back++;
      credits++;
    end else begin
      $display("A credit came back with no instruction outstanding");
      fail_run();
    end
  endtask

  task automatic check_retire();
    retire_t exp;
    assert (expected_q.size() != 0) begin
      exp = expected_q.pop_front();
      assert (retire.rd == exp.rd) begin
        assert (retire.value == exp.value) else begin
          $display("[FAIL] %0t retire.value expected %h got %h", $time, exp.value,
                   retire.value);
          fail_run();
        end
      end else begin
        $display("[FAIL] %0t retire.rd expected %0d got %0d", $time, exp.rd, retire.rd);
        fail_run();
      end
    end else begin
      $display("A retire came out with no legal instruction outstanding");
      fail_run();
    end
  endtask

  // Sampled mid-cycle, away from the driving edge
  always @(negedge clk) begin
    if (!reset) begin
      if (credit_return) begin
        count_credit();
      end
      if (retire.valid) begin
        check_retire();
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", cycles);
      fail_run();
    end
  end

  initial begin
    instr_valid = 1'b0;
    instr = '0;
    rnd = 32'hc865;
    credits = BUF_DEPTH;
    sent = 0;
    credits_back = 0;
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    @(negedge reset);
    // Send on a credit, idle about one cycle in four
    while (sent < NUM_INSTR) begin
      @(posedge clk);
      #1;
      rnd = xorshift(rnd);
      if (credits > 0 && rnd[1:0] != 2'b00) begin
        send_instruction();
      end else begin
        instr_valid = 1'b0;
      end
    end
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    // Last pop is behind the last credit, the pipeline drains within a few cycles
    while (credits != BUF_DEPTH) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
    if (credits_back == NUM_INSTR && expected_q.size() == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Run ended with %0d credits back and %0d retires missing", credits_back,
               expected_q.size());
      fail_run();
    end
  end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Released just after the last reset edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire
